/* testbench/tlb_stimulus.txt */
# op addr data expected, all hex; expected is ignored on W, data on R and P
# W write, R read word, P read physical address, T starts a named test
T reset_state
W 18 12345000 0
R 18 0 00000000
P 1C 0 00000000
T page_4k
W 10 00000005 0
W 00 00402000 0
W 08 01234513 0
W 0C 00ABCD2D 0
W 04 0C000000 0
W 14 00000001 0
W 18 00402ABC 0
R 18 0 00000047
P 1C 0 12345ABC
W 18 00403DEF 0
R 18 0 000000B3
P 1C 0 0ABCDDEF
T page_2m
W 00 80000000 0
W 08 00140015 0
W 0C 003A000B 0
W 04 15000001 0
W 14 00000001 0
W 18 80123456 0
R 18 0 00000053
P 1C 0 01523456
W 18 80345678 0
R 18 0 00000027
P 1C 0 03B45678
T asid_and_global
W 00 10000000 0
W 08 05555541 0
W 0C 06666641 0
W 04 0C000002 0
W 14 00000001 0
W 10 00000006 0
W 18 00402ABC 0
R 18 0 00000000
P 1C 0 00000000
W 18 80123456 0
R 18 0 00000000
W 18 10000123 0
R 18 0 00000003
P 1C 0 55555123
W 18 10001FFF 0
R 18 0 00000003
P 1C 0 66666FFF
W 10 00000005 0
T search
W 04 0C00000F 0
W 00 80000000 0
W 14 00000002 0
R 04 0 0C000001
W 00 00402000 0
W 14 00000002 0
R 04 0 0C000000
W 00 7FFFE000 0
W 14 00000002 0
R 04 0 8C000000
R 00 0 7FFFE000
T invalidate
W 10 00000007 0
W 00 40000000 0
W 08 07777701 0
W 0C 08888801 0
W 04 0C000003 0
W 14 00000001 0
W 10 00000005 0
W 14 00000023 0
W 18 10000123 0
R 18 0 00000000
W 18 00402ABC 0
R 18 0 00000047
P 1C 0 12345ABC
W 14 00000033 0
W 18 00402ABC 0
R 18 0 00000000
W 18 80123456 0
R 18 0 00000000
W 10 00000007 0
W 18 40000123 0
R 18 0 00000000
W 10 00000005 0
W 00 00402000 0
W 04 0C000000 0
W 14 00000001 0
W 10 00000007 0
W 00 40000000 0
W 04 0C000003 0
W 14 00000001 0
W 14 00000043 0
W 18 40000123 0
R 18 0 00000000
W 10 00000005 0
W 18 00402123 0
R 18 0 00000003
P 1C 0 77777123
W 00 40000000 0
W 04 0C000003 0
W 14 00000001 0
W 00 00402000 0
W 14 00000053 0
W 18 00402123 0
R 18 0 00000000
P 1C 0 00000000
W 18 40000123 0
R 18 0 00000003
P 1C 0 77777123

/* vlog.f */
source/tlb_pkg.sv
source/tlb_bus_pkg.sv
source/tlb_entry.sv
source/tlb_hit_select.sv
source/tlb_wb_regs.sv
source/tlb_top.sv
testbench/tb_tlb_top.sv

/* testbench/tb_tlb_top.sv */
`timescale 1ns/100ps

module tb_tlb_top;

    localparam int ack_timeout = 20;

    logic                 clk;
    logic                 reset;
    tlb_bus_pkg::wb_req_t bus_req;
    tlb_bus_pkg::wb_rsp_t bus_rsp;

    int    pass_count;
    int    fail_count;
    int    test_errors;
    string test_name;
    bit    in_test;

    tlb_top #(.tlb_num(16)) DUT (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // one Wishbone classic access driven 1 ns after the edge
    task automatic bus_access(input logic we, input tlb_bus_pkg::wb_adr_t adr,
                              input tlb_bus_pkg::wb_data_t wdata,
                              output tlb_bus_pkg::wb_data_t rdata, output bit ok);
        int cycles;
        @(posedge clk);
        #1;
        bus_req.cyc   = 1'b1;
        bus_req.stb   = 1'b1;
        bus_req.we    = we;
        bus_req.adr   = adr;
        bus_req.dat_w = wdata;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < ack_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
            if (bus_rsp.ack) begin
                ok = 1'b1;
            end
        end
        rdata       = bus_rsp.dat_r;
        bus_req.cyc = 1'b0;
        bus_req.stb = 1'b0;
        bus_req.we  = 1'b0;
        if (!ok) begin
            $display("no ack from the DUT within %0d cycles, address %h", ack_timeout, adr);
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input tlb_bus_pkg::wb_data_t actual,
                              input tlb_bus_pkg::wb_data_t expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic check_paddr(input string name, input tlb_pkg::paddr_t actual,
                               input tlb_pkg::paddr_t expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            test_errors++;
        end
    endtask

    task automatic run_op(input string op, input tlb_bus_pkg::wb_adr_t adr,
                          input tlb_bus_pkg::wb_data_t data,
                          input tlb_bus_pkg::wb_data_t expected);
        tlb_bus_pkg::wb_data_t rdata;
        bit ok;
        if (op == "W") begin
            bus_access(1'b1, adr, data, rdata, ok);
        end else begin
            bus_access(1'b0, adr, '0, rdata, ok);
            if (ok && op == "R") begin
                check_word($sformatf("dat_r[%h]", adr), rdata, expected);
            end else if (ok) begin
                check_paddr("xlat_pa", tlb_pkg::paddr_t'(rdata), tlb_pkg::paddr_t'(expected));
            end
        end
    endtask

    task automatic close_test();
        if (in_test || test_errors != 0) begin
            if (test_errors == 0) begin
                pass_count++;
                $display("test %s passed", test_name);
            end else begin
                fail_count++;
                $display("test %s failed with %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          code;
        string       op;
        string       rest;
        logic [31:0] adr_v;
        logic [31:0] data_v;
        logic [31:0] exp_v;
        bus_req     = '0;
        reset       = 1'b1;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        test_name   = "setup";
        in_test     = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        fd = $fopen("testbench/tlb_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/tlb_stimulus.txt");
            fail_count++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %s", op);
                if (code != 1) begin
                    break;
                end
                if (op == "#") begin
                    code = $fgets(rest, fd);
                end else if (op == "T") begin
                    close_test();
                    code    = $fscanf(fd, " %s", test_name);
                    in_test = 1'b1;
                end else if (op == "W" || op == "R" || op == "P") begin
                    code = $fscanf(fd, " %h %h %h", adr_v, data_v, exp_v);
                    if (code != 3) begin
                        $display("malformed stimulus line after operation %s", op);
                        test_errors++;
                    end else begin
                        run_op(op, adr_v[4:0], data_v, exp_v);
                    end
                end else begin
                    $display("unknown stimulus operation %s", op);
                    test_errors++;
                end
            end
            close_test();
            $fclose(fd);
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* source/tlb_top.sv */
`timescale 1ns/100ps

module tlb_top #(
    parameter int tlb_num = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tlb_bus_pkg::wb_req_t bus_req,
    output tlb_bus_pkg::wb_rsp_t bus_rsp
);
    localparam int idx_w = $clog2(tlb_num);

    tlb_pkg::tlb_entry_t  wr_data;
    logic [tlb_num-1:0]   wr_sel;
    tlb_pkg::tlb_inv_t    inv;
    tlb_pkg::tlb_query_t  query;
    tlb_pkg::tlb_result_t result;
    logic [idx_w-1:0]     hit_index;
    logic [tlb_num-1:0]   hits;
    tlb_pkg::tlb_page_t   pages [tlb_num];
    tlb_pkg::ps_t         entry_ps [tlb_num];

    tlb_wb_regs #(.tlb_num(tlb_num)) u_regs (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .result    (result),
        .hit_index (hit_index),
        .bus_rsp   (bus_rsp),
        .wr_data   (wr_data),
        .wr_sel    (wr_sel),
        .inv       (inv),
        .query     (query)
    );

    for (genvar i = 0; i < tlb_num; i++) begin : g_entry
        tlb_entry u_entry (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (wr_sel[i]),
            .wr_data (wr_data),
            .inv     (inv),
            .query   (query),
            .hit     (hits[i]),
            .page    (pages[i]),
            .ps      (entry_ps[i])
        );
    end

    tlb_hit_select #(.tlb_num(tlb_num)) u_hit_select (
        .hits      (hits),
        .pages     (pages),
        .entry_ps  (entry_ps),
        .query     (query),
        .result    (result),
        .hit_index (hit_index)
    );

endmodule

/* source/tlb_wb_regs.sv */
`timescale 1ns/100ps

module tlb_wb_regs #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic                 clk,
    input  logic                 reset,
    input  tlb_bus_pkg::wb_req_t bus_req,
    input  tlb_pkg::tlb_result_t result,
    input  logic [idx_w-1:0]     hit_index,
    output tlb_bus_pkg::wb_rsp_t bus_rsp,
    output tlb_pkg::tlb_entry_t  wr_data,
    output logic [tlb_num-1:0]   wr_sel,
    output tlb_pkg::tlb_inv_t    inv,
    output tlb_pkg::tlb_query_t  query
);
    tlb_pkg::vppn_t        ehi_vppn;
    logic [idx_w-1:0]      idx;
    tlb_pkg::ps_t          idx_ps;
    logic                  idx_ne;
    tlb_pkg::tlb_page_t    elo0_page;
    tlb_pkg::tlb_page_t    elo1_page;
    logic                  elo0_g;
    logic                  elo1_g;
    tlb_pkg::asid_t        asid;
    tlb_pkg::vaddr_t       xlat_va;
    tlb_bus_pkg::wb_data_t xlat_status;
    tlb_pkg::paddr_t       xlat_pa;
    tlb_bus_pkg::wb_data_t xlat_word;
    tlb_bus_pkg::wb_data_t rd_data;
    tlb_bus_pkg::wb_data_t dat_r;
    logic                  ack;
    logic                  access;
    logic                  wr_access;
    logic                  cmd_wr;
    logic                  tlbwr_go;
    logic                  srch_go;
    logic                  xlat_go;
    tlb_bus_pkg::cmd_kind_t cmd_kind;

    function automatic tlb_pkg::tlb_page_t elo_page(tlb_bus_pkg::wb_data_t d);
        tlb_pkg::tlb_page_t p;
        p.ppn   = d[tlb_bus_pkg::ELO_PPN_LSB +: 20];
        p.plv   = d[tlb_bus_pkg::ELO_PLV_LSB +: 2];
        p.mat   = d[tlb_bus_pkg::ELO_MAT_LSB +: 2];
        p.dirty = d[tlb_bus_pkg::ELO_D_BIT];
        p.valid = d[tlb_bus_pkg::ELO_V_BIT];
        return p;
    endfunction

    function automatic tlb_bus_pkg::wb_data_t elo_word(tlb_pkg::tlb_page_t p, logic g);
        tlb_bus_pkg::wb_data_t w;
        w = '0;
        w[tlb_bus_pkg::ELO_PPN_LSB +: 20] = p.ppn;
        w[tlb_bus_pkg::ELO_PLV_LSB +: 2]  = p.plv;
        w[tlb_bus_pkg::ELO_MAT_LSB +: 2]  = p.mat;
        w[tlb_bus_pkg::ELO_D_BIT]         = p.dirty;
        w[tlb_bus_pkg::ELO_V_BIT]         = p.valid;
        w[tlb_bus_pkg::ELO_G_BIT]         = g;
        return w;
    endfunction

    // first cycle of an access whose effects land on the ack edge
    assign access    = bus_req.cyc && bus_req.stb && !ack;
    assign wr_access = access && bus_req.we;
    assign cmd_wr    = wr_access && (bus_req.adr == tlb_bus_pkg::REG_CMD);
    assign cmd_kind  = bus_req.dat_w[tlb_bus_pkg::CMD_KIND_LSB +: 3];
    assign tlbwr_go  = cmd_wr && (cmd_kind == tlb_bus_pkg::CMD_TLBWR);
    assign srch_go   = cmd_wr && (cmd_kind == tlb_bus_pkg::CMD_TLBSRCH);
    assign xlat_go   = wr_access && (bus_req.adr == tlb_bus_pkg::REG_XLAT_VA);

    assign inv.valid = cmd_wr && (cmd_kind == tlb_bus_pkg::CMD_INVTLB);
    assign inv.op    = bus_req.dat_w[tlb_bus_pkg::CMD_OP_LSB +: 5];
    assign inv.asid  = asid;
    assign inv.vppn  = ehi_vppn;

    // exist is the inverse of not-exist as in the CSR
    assign wr_data.exist = !idx_ne;
    assign wr_data.vppn  = ehi_vppn;
    assign wr_data.ps    = idx_ps;
    assign wr_data.asid  = asid;
    assign wr_data.g     = elo0_g && elo1_g;
    assign wr_data.page0 = elo0_page;
    assign wr_data.page1 = elo1_page;

    always_comb begin
        wr_sel      = '0;
        wr_sel[idx] = tlbwr_go;
    end

    // a lookup address write translates the new address in the same cycle
    always_comb begin
        query.asid = asid;
        if (srch_go) begin
            query.va = {ehi_vppn, 13'b0};
        end else if (xlat_go) begin
            query.va = bus_req.dat_w;
        end else begin
            query.va = xlat_va;
        end
    end

    always_comb begin
        xlat_word = '0;
        xlat_word[tlb_bus_pkg::XS_FOUND_BIT]    = result.found;
        xlat_word[tlb_bus_pkg::XS_V_BIT]        = result.page.valid;
        xlat_word[tlb_bus_pkg::XS_D_BIT]        = result.page.dirty;
        xlat_word[tlb_bus_pkg::XS_PLV_LSB +: 2] = result.page.plv;
        xlat_word[tlb_bus_pkg::XS_MAT_LSB +: 2] = result.page.mat;
    end

    always_comb begin
        case (bus_req.adr)
            tlb_bus_pkg::REG_EHI: rd_data =
                tlb_bus_pkg::wb_data_t'(ehi_vppn) << tlb_bus_pkg::EHI_VPPN_LSB;
            tlb_bus_pkg::REG_IDX: rd_data = tlb_bus_pkg::wb_data_t'(idx)
                | (tlb_bus_pkg::wb_data_t'(idx_ps) << tlb_bus_pkg::IDX_PS_LSB)
                | (tlb_bus_pkg::wb_data_t'(idx_ne) << tlb_bus_pkg::IDX_NE_BIT);
            tlb_bus_pkg::REG_ELO0: rd_data = elo_word(elo0_page, elo0_g);
            tlb_bus_pkg::REG_ELO1: rd_data = elo_word(elo1_page, elo1_g);
            tlb_bus_pkg::REG_ASID: rd_data = tlb_bus_pkg::wb_data_t'(asid);
            tlb_bus_pkg::REG_XLAT_VA: rd_data = xlat_status;
            tlb_bus_pkg::REG_XLAT_PA: rd_data = xlat_pa;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack         <= 1'b0;
            xlat_status <= '0;
            xlat_pa     <= '0;
        end else begin
            ack <= access;
            if (xlat_go) begin
                xlat_status <= xlat_word;
                xlat_pa     <= result.pa;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_access) begin
            case (bus_req.adr)
                tlb_bus_pkg::REG_EHI: begin
                    ehi_vppn <= bus_req.dat_w[tlb_bus_pkg::EHI_VPPN_LSB +: 19];
                end
                tlb_bus_pkg::REG_IDX: begin
                    idx    <= bus_req.dat_w[idx_w-1:0];
                    idx_ps <= bus_req.dat_w[tlb_bus_pkg::IDX_PS_LSB +: 6];
                    idx_ne <= bus_req.dat_w[tlb_bus_pkg::IDX_NE_BIT];
                end
                tlb_bus_pkg::REG_ELO0: begin
                    elo0_page <= elo_page(bus_req.dat_w);
                    elo0_g    <= bus_req.dat_w[tlb_bus_pkg::ELO_G_BIT];
                end
                tlb_bus_pkg::REG_ELO1: begin
                    elo1_page <= elo_page(bus_req.dat_w);
                    elo1_g    <= bus_req.dat_w[tlb_bus_pkg::ELO_G_BIT];
                end
                tlb_bus_pkg::REG_ASID: asid <= bus_req.dat_w[9:0];
                tlb_bus_pkg::REG_XLAT_VA: xlat_va <= bus_req.dat_w;
                default: ;
            endcase
        end
        // search keeps the old index on a miss
        if (srch_go) begin
            idx_ne <= !result.found;
            if (result.found) begin
                idx <= hit_index;
            end
        end
        if (access && !bus_req.we) begin
            dat_r <= rd_data;
        end
    end

    assign bus_rsp.ack   = ack;
    assign bus_rsp.dat_r = dat_r;

    a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
        ack |-> $past(bus_req.cyc && bus_req.stb))
        else $error("ack without a preceding cyc/stb cycle");

endmodule

/* source/tlb_hit_select.sv */
`timescale 1ns/100ps

module tlb_hit_select #(
    parameter int tlb_num = 16,
    localparam int idx_w = $clog2(tlb_num)
) (
    input  logic [tlb_num-1:0]   hits,
    input  tlb_pkg::tlb_page_t   pages [tlb_num],
    input  tlb_pkg::ps_t         entry_ps [tlb_num],
    input  tlb_pkg::tlb_query_t  query,
    output tlb_pkg::tlb_result_t result,
    output logic [idx_w-1:0]     hit_index
);
    logic               found;
    logic [idx_w-1:0]   sel;
    tlb_pkg::tlb_page_t sel_page;
    tlb_pkg::ps_t       sel_ps;
    tlb_pkg::paddr_t    pa;

    // walk down so the lowest hitting index wins
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = tlb_num - 1; i >= 0; i--) begin
            if (hits[i]) begin
                found = 1'b1;
                sel   = idx_w'(i);
            end
        end
    end

    assign sel_page = found ? pages[sel] : '0;
    assign sel_ps   = found ? entry_ps[sel] : '0;

    always_comb begin
        if (!found) begin
            pa = '0;
        end else if (sel_ps == tlb_pkg::PS_4K) begin
            pa = {sel_page.ppn, query.va[11:0]};
        end else begin
            pa = {sel_page.ppn[19:9], query.va[20:0]};
        end
    end

    assign result.found = found;
    assign result.ps    = sel_ps;
    assign result.page  = sel_page;
    assign result.pa    = pa;
    assign hit_index    = sel;

    // overlapping entries are a software error
    always_comb begin
        a_onehot_hit: assert final ($onehot0(hits))
            else $error("several TLB entries hit va %h", query.va);
    end

endmodule

/* source/tlb_entry.sv */
`timescale 1ns/100ps

module tlb_entry (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  tlb_pkg::tlb_entry_t wr_data,
    input  tlb_pkg::tlb_inv_t   inv,
    input  tlb_pkg::tlb_query_t query,
    output logic                hit,
    output tlb_pkg::tlb_page_t  page,
    output tlb_pkg::ps_t        ps
);
    tlb_pkg::tlb_entry_t ent;
    tlb_pkg::vppn_t      vppn_mask;
    logic                is_2m;
    logic                q_vppn_eq;
    logic                odd;
    logic                inv_asid_eq;
    logic                inv_vppn_eq;
    logic                inv_sel;

    assign is_2m = (ent.ps == tlb_pkg::PS_2M);

    // low 9 vppn bits belong to the page offset on 2 MB pages
    assign vppn_mask = is_2m ? 19'h7fe00 : 19'h7ffff;

    assign q_vppn_eq = ((ent.vppn ^ query.va[31:13]) & vppn_mask) == '0;
    assign hit       = ent.exist && q_vppn_eq && (ent.g || ent.asid == query.asid);

    assign odd  = is_2m ? query.va[21] : query.va[12];
    assign page = odd ? ent.page1 : ent.page0;
    assign ps   = ent.ps;

    assign inv_asid_eq = (ent.asid == inv.asid);
    assign inv_vppn_eq = ((ent.vppn ^ inv.vppn) & vppn_mask) == '0;

    always_comb begin
        case (inv.op)
            5'd0, 5'd1: inv_sel = 1'b1;
            5'd2: inv_sel = ent.g;
            5'd3: inv_sel = !ent.g;
            5'd4: inv_sel = !ent.g && inv_asid_eq;
            5'd5: inv_sel = !ent.g && inv_asid_eq && inv_vppn_eq;
            5'd6: inv_sel = (ent.g || inv_asid_eq) && inv_vppn_eq;
            default: inv_sel = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ent.exist <= 1'b0;
        end else if (wr_en) begin
            ent <= wr_data;
        end else if (inv.valid && inv_sel) begin
            ent.exist <= 1'b0;
        end
    end

    // one command per bus access
    a_no_wr_inv: assert property (@(posedge clk) disable iff (reset)
        !(wr_en && inv.valid))
        else $error("entry write and invalidate in the same cycle");

endmodule

/* source/tlb_bus_pkg.sv */
package tlb_bus_pkg;

    typedef logic [31:0] wb_data_t;
    typedef logic [4:0]  wb_adr_t;
    typedef logic [2:0]  cmd_kind_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat_w;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat_r;
    } wb_rsp_t;

    localparam wb_adr_t REG_EHI     = 5'h00;
    localparam wb_adr_t REG_IDX     = 5'h04;
    localparam wb_adr_t REG_ELO0    = 5'h08;
    localparam wb_adr_t REG_ELO1    = 5'h0C;
    localparam wb_adr_t REG_ASID    = 5'h10;
    localparam wb_adr_t REG_CMD     = 5'h14;
    localparam wb_adr_t REG_XLAT_VA = 5'h18;
    localparam wb_adr_t REG_XLAT_PA = 5'h1C;

    localparam cmd_kind_t CMD_TLBWR   = 3'd1;
    localparam cmd_kind_t CMD_TLBSRCH = 3'd2;
    localparam cmd_kind_t CMD_INVTLB  = 3'd3;

    localparam int EHI_VPPN_LSB = 13;
    localparam int IDX_PS_LSB   = 24;
    localparam int IDX_NE_BIT   = 31;
    localparam int ELO_V_BIT    = 0;
    localparam int ELO_D_BIT    = 1;
    localparam int ELO_PLV_LSB  = 2;
    localparam int ELO_MAT_LSB  = 4;
    localparam int ELO_G_BIT    = 6;
    localparam int ELO_PPN_LSB  = 8;
    localparam int CMD_KIND_LSB = 0;
    localparam int CMD_OP_LSB   = 4;

    // translation status word
    localparam int XS_FOUND_BIT = 0;
    localparam int XS_V_BIT     = 1;
    localparam int XS_D_BIT     = 2;
    localparam int XS_PLV_LSB   = 4;
    localparam int XS_MAT_LSB   = 6;

endpackage

/* source/tlb_pkg.sv */
package tlb_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // page-pair number from va bits 31..13
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;

    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_2M = 6'd21;

    typedef struct packed {
        ppn_t ppn;
        plv_t plv;
        mat_t mat;
        logic dirty;
        logic valid;
    } tlb_page_t;

    typedef struct packed {
        logic      exist;
        vppn_t     vppn;
        ps_t       ps;
        asid_t     asid;
        logic      g;
        tlb_page_t page0;
        tlb_page_t page1;
    } tlb_entry_t;

    typedef struct packed {
        vaddr_t va;
        asid_t  asid;
    } tlb_query_t;

    // invalidate request with op as in the invtlb instruction
    typedef struct packed {
        logic       valid;
        logic [4:0] op;
        asid_t      asid;
        vppn_t      vppn;
    } tlb_inv_t;

    typedef struct packed {
        logic      found;
        ps_t       ps;
        tlb_page_t page;
        paddr_t    pa;
    } tlb_result_t;

endpackage
